//--- Makefile
SIM      := verilator
TOP      := tb_mips_exc_unit
FILELIST := compile.f
BUILD    := obj_dir
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(BUILD)
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^TEST PASSED$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- compile.f
rtl/cp0_pkg.sv
rtl/trap_if.sv
rtl/irq_pending.sv
rtl/exc_prioritizer.sv
rtl/cp0_regs.sv
rtl/mips_exc_unit.sv
dv/tb_mips_exc_unit.sv

//--- dv/tb_mips_exc_unit.sv
`timescale 1ns/1ps

module tb_mips_exc_unit;
	import cp0_pkg::*;

	localparam int CYCLE_LIMIT = 2000;
	localparam time DRIVE_DELAY = 10ns;

	logic                 clk;
	logic                 rst;
	logic [NUM_HWIRQ-1:0] hwirq;
	exc_flags_t           flags;
	logic [31:0]          pc;
	logic                 in_bds;
	logic                 write_en;
	logic [4:0]           write_addr;
	logic [31:0]          write_data;
	logic [4:0]           read_addr;
	logic                 exit_isr;
	logic [31:0]          read_data;
	logic [31:0]          epc;
	logic                 trap;

	// expected values for the coming edge.
	logic        checking;
	logic        exp_trap;
	logic [31:0] exp_read;
	logic [31:0] exp_epc;

	// shadow state of the cp0 registers.
	logic [31:0]          sh_sr;
	logic [4:0]           sh_code;
	logic                 sh_bd;
	logic [31:0]          sh_epc;
	logic [NUM_HWIRQ-1:0] sh_s1;
	logic [NUM_HWIRQ-1:0] sh_s2;
	logic [NUM_HWIRQ-1:0] sh_ip;

	logic [31:0] rng;
	int          errors;
	int          cycle_count;

	mips_exc_unit i_mips_exc_unit (
		.clk          (clk),
		.rst          (rst),
		.hwirq_i      (hwirq),
		.adel_i       (flags.adel),
		.ades_i       (flags.ades),
		.sys_i        (flags.sys),
		.ri_i         (flags.ri),
		.ov_i         (flags.ov),
		.pc_i         (pc),
		.in_bds_i     (in_bds),
		.write_en_i   (write_en),
		.write_addr_i (write_addr),
		.write_data_i (write_data),
		.read_addr_i  (read_addr),
		.exit_isr_i   (exit_isr),
		.read_data_o  (read_data),
		.epc_o        (epc),
		.trap_o       (trap)
	);

	always #50 clk = ~clk; // 100 ns period.

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TEST FAILED");
			$finish;
		end
	end

	a_trap_match: assert property (@(posedge clk) disable iff (rst)
		checking |-> (trap == exp_trap))
	else begin
		errors = errors + 1;
		$display("error: trap_o expected %h actual %h", $sampled(exp_trap), $sampled(trap));
	end

	a_read_match: assert property (@(posedge clk) disable iff (rst)
		checking |-> (read_data == exp_read))
	else begin
		errors = errors + 1;
		$display("error: read_data_o (addr %h) expected %h actual %h",
			$sampled(read_addr), $sampled(exp_read), $sampled(read_data));
	end

	a_epc_match: assert property (@(posedge clk) disable iff (rst)
		checking |-> (epc == exp_epc))
	else begin
		errors = errors + 1;
		$display("error: epc_o expected %h actual %h", $sampled(exp_epc), $sampled(epc));
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic next_rand(output logic [31:0] value);
		rng = xorshift32(rng);
		value = rng;
	endtask

	// ADEL, RI, SYS, OV, ADES in that order.
	function automatic logic [4:0] highest_code(input exc_flags_t f);
		if (f.adel) return EXC_ADEL;
		if (f.ri) return EXC_RI;
		if (f.sys) return EXC_SYS;
		if (f.ov) return EXC_OV;
		if (f.ades) return EXC_ADES;
		return EXC_INT;
	endfunction

	function automatic logic [31:0] shadow_read(input logic [4:0] addr);
		logic [31:0] cause;
		cause = '0;
		cause[CAUSE_BD_BIT] = sh_bd;
		cause[CAUSE_IP_LSB +: NUM_HWIRQ] = sh_ip;
		cause[CAUSE_EXC_LSB +: EXC_CODE_W] = sh_code;
		case (addr)
			REG_SR:    return sh_sr;
			REG_CAUSE: return cause;
			REG_EPC:   return sh_epc;
			REG_PRID:  return CP0_PRID;
			default:   return 32'h0;
		endcase
	endfunction

	function automatic logic irq_expected();
		return (|(sh_ip & sh_sr[15:10])) && sh_sr[0] && !sh_sr[1];
	endfunction

	// one clock: set expectations, cross the edge, advance the shadow model.
	task automatic step();
		logic irq_now;
		logic trap_now;
		logic cause_hold;
		logic writable;
		irq_now = irq_expected();
		trap_now = irq_now || ((|flags) && !sh_sr[1]);
		writable = write_en && (write_addr == REG_SR || write_addr == REG_CAUSE ||
			write_addr == REG_EPC);
		cause_hold = writable && (write_addr == REG_CAUSE) && !trap_now;
		exp_trap = trap_now;
		exp_read = shadow_read(read_addr);
		exp_epc = sh_epc;
		@(posedge clk);
		if (trap_now) begin
			sh_sr[1] = 1'b1;
			sh_bd = in_bds;
			sh_epc = in_bds ? pc - 32'd4 : pc;
			sh_code = irq_now ? EXC_INT : highest_code(flags);
		end else if (writable) begin
			if (write_addr == REG_SR) sh_sr = write_data & SR_WRITE_MASK;
			else if (write_addr == REG_EPC) sh_epc = write_data;
		end else if (exit_isr) begin
			sh_sr[1] = 1'b0;
		end
		if (!cause_hold) sh_ip = sh_s2; // IP lags the lines by 3 edges.
		sh_s2 = sh_s1;
		sh_s1 = hwirq;
		#(DRIVE_DELAY);
		write_en = 1'b0; // strobes last one cycle.
		exit_isr = 1'b0;
		flags = '0;
	endtask

	task automatic read_reg(input logic [4:0] addr);
		read_addr = addr;
		step();
	endtask

	task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
		write_en = 1'b1;
		write_addr = addr;
		write_data = data;
		read_addr = addr;
		step();
		read_reg(addr);
	endtask

	task automatic random_flags();
		logic [31:0] r;
		next_rand(r);
		flags = exc_flags_t'(r[4:0]);
		if (r[4:0] == 5'd0) flags.sys = 1'b1;
	endtask

	task automatic test_reset_reads();
		read_reg(REG_SR);
		read_reg(REG_CAUSE);
		read_reg(REG_EPC);
		read_reg(REG_PRID);
		read_reg(5'd3);
		read_reg(5'd20);
	endtask

	task automatic test_writes();
		logic [31:0] r;
		for (int i = 0; i < 8; i++) begin
			next_rand(r);
			write_reg(REG_SR, r);
			next_rand(r);
			write_reg(REG_EPC, r);
			next_rand(r);
			write_reg(REG_CAUSE, r); // ExcCode and BD must hold.
		end
		write_reg(REG_SR, 32'h0);
	endtask

	task automatic test_exceptions();
		logic [31:0] r;
		for (int i = 0; i < 32; i++) begin
			next_rand(r);
			pc = {r[31:2], 2'b00};
			next_rand(r);
			in_bds = r[0];
			random_flags();
			read_reg(REG_CAUSE); // trap in this cycle.
			read_reg(REG_SR);
			random_flags(); // blocked while EXL is set.
			read_reg(REG_CAUSE);
			exit_isr = 1'b1;
			read_reg(REG_EPC);
			read_reg(REG_SR);
		end
	endtask

	task automatic test_interrupts();
		logic [31:0] r;
		logic [31:0] d;
		logic        same_cycle_exc;
		for (int i = 0; i < 20; i++) begin
			next_rand(r);
			write_en = 1'b1;
			write_addr = REG_SR;
			write_data = {16'h0, r[5:0], 9'h0, r[6]};
			read_reg(REG_SR);
			hwirq = r[13:8] | (6'd1 << (r[18:16] % 6));
			same_cycle_exc = r[21];
			next_rand(d);
			pc = {d[31:2], 2'b00};
			in_bds = d[0];
			read_reg(REG_CAUSE);
			read_reg(REG_CAUSE);
			if (r[20] && !same_cycle_exc) begin
				write_en = 1'b1; // IP holds for this edge.
				write_addr = REG_CAUSE;
				write_data = d;
			end
			read_reg(REG_CAUSE);
			if (same_cycle_exc) random_flags(); // interrupt should win.
			read_reg(REG_CAUSE);
			read_reg(REG_CAUSE);
			hwirq = '0;
			read_reg(REG_SR);
			for (int k = 0; k < 3; k++) begin
				read_reg(REG_CAUSE);
			end
			exit_isr = 1'b1;
			read_reg(REG_EPC);
			read_reg(REG_SR);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		hwirq = '0;
		flags = '0;
		pc = 32'h0;
		in_bds = 1'b0;
		write_en = 1'b0;
		write_addr = 5'd0;
		write_data = 32'h0;
		read_addr = 5'd0;
		exit_isr = 1'b0;
		checking = 1'b0;
		exp_trap = 1'b0;
		exp_read = 32'h0;
		exp_epc = 32'h0;
		sh_sr = 32'h0;
		sh_code = EXC_INT;
		sh_bd = 1'b0;
		sh_epc = 32'h0;
		sh_s1 = '0;
		sh_s2 = '0;
		sh_ip = '0;
		rng = 32'haf35ed4d;
		errors = 0;
		cycle_count = 0;

		repeat (8) @(posedge clk);
		#(DRIVE_DELAY);
		rst = 1'b0;
		checking = 1'b1;

		test_reset_reads();
		test_writes();
		test_exceptions();
		test_interrupts();

		checking = 1'b0; // last edge already checked.
		$display("checks done after %0d cycles, %0d errors", cycle_count, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- rtl/cp0_pkg.sv
package cp0_pkg;

	// cp0 register numbers as seen by mtc0 / mfc0.
	typedef enum logic [4:0] {
		REG_SR    = 5'd12,
		REG_CAUSE = 5'd13,
		REG_EPC   = 5'd14,
		REG_PRID  = 5'd15
	} cp0_reg_e;

	// values of the Cause.ExcCode field.
	typedef enum logic [4:0] {
		EXC_INT  = 5'd0,  // hardware interrupt.
		EXC_ADEL = 5'd4,  // address error on load or fetch.
		EXC_ADES = 5'd5,  // address error on store.
		EXC_SYS  = 5'd8,  // syscall.
		EXC_RI   = 5'd10, // reserved instruction.
		EXC_OV   = 5'd12  // arithmetic overflow.
	} exc_code_e;

	// exception flags of the instruction in the memory stage.
	typedef struct packed {
		logic adel;
		logic ades;
		logic sys;
		logic ri;
		logic ov;
	} exc_flags_t;

	// processor id word.
	localparam logic [31:0] CP0_PRID = 32'h0000_4a01;

	localparam int NUM_HWIRQ = 6;

	// status register fields.
	localparam int SR_IE_BIT  = 0;  // global interrupt enable.
	localparam int SR_EXL_BIT = 1;  // exception level.
	localparam int SR_IM_LSB  = 10; // interrupt mask, NUM_HWIRQ bits.

	// cause register fields.
	localparam int CAUSE_EXC_LSB = 2;  // ExcCode, 5 bits.
	localparam int CAUSE_IP_LSB  = 10; // pending hardware lines.
	localparam int CAUSE_BD_BIT  = 31; // trap in a delay slot.

	localparam int EXC_CODE_W = 5;

	// only IM, EXL and IE can be written by mtc0.
	localparam logic [31:0] SR_WRITE_MASK = 32'h0000_fc03;

	// delay slot instruction sits one word after its branch.
	localparam logic [31:0] BDS_PC_OFFSET = 32'd4;

endpackage

//--- rtl/cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs (
	input  logic                          clk,
	input  logic                          rst,
	trap_if.dst                           trap,
	input  logic [cp0_pkg::NUM_HWIRQ-1:0] ip_i,
	input  logic                          write_en_i,
	input  cp0_pkg::cp0_reg_e             write_addr_i,
	input  logic [31:0]                   write_data_i,
	input  cp0_pkg::cp0_reg_e             read_addr_i,
	input  logic                          exit_isr_i,
	output logic [31:0]                   read_data_o,
	output logic [31:0]                   epc_o,
	output logic                          trap_o,
	output logic                          mtc0_cause_o
);
	import cp0_pkg::*;

	logic [31:0] sr_q;
	exc_code_e   exc_code_q;
	logic        bd_q;
	logic [31:0] epc_q;

	logic                 sr_ie;
	logic                 sr_exl;
	logic [NUM_HWIRQ-1:0] sr_im;
	logic                 have_irq;
	logic                 have_exc;
	logic                 write_valid;
	logic [31:0]          cause_word;

	assign sr_ie  = sr_q[SR_IE_BIT];
	assign sr_exl = sr_q[SR_EXL_BIT];
	assign sr_im  = sr_q[SR_IM_LSB +: NUM_HWIRQ];

	// nothing is taken while a handler runs.
	assign have_irq = (|(ip_i & sr_im)) && sr_ie && !sr_exl;
	assign have_exc = trap.exc_valid && !sr_exl;
	assign trap_o   = have_irq || have_exc;

	// PRID is read-only, so it does not count as a write.
	always_comb begin
		write_valid = 1'b0;
		if (write_en_i) begin
			case (write_addr_i)
				REG_SR, REG_CAUSE, REG_EPC: write_valid = 1'b1;
				default:                    write_valid = 1'b0;
			endcase
		end
	end

	// freezes IP in irq_pending for this cycle.
	assign mtc0_cause_o = write_valid && (write_addr_i == REG_CAUSE) && !trap_o;

	// trap beats mtc0, mtc0 beats eret.
	always_ff @(posedge clk) begin
		if (rst) begin
			sr_q       <= '0;
			exc_code_q <= EXC_INT;
			bd_q       <= 1'b0;
			epc_q      <= '0;
		end else if (trap_o) begin
			sr_q[SR_EXL_BIT] <= 1'b1;
			bd_q             <= trap.exc_bds;
			epc_q            <= trap.exc_epc;
			if (have_irq) begin
				exc_code_q <= EXC_INT; // interrupt wins over a same cycle exception.
			end else begin
				exc_code_q <= trap.exc_code;
			end
		end else if (write_valid) begin
			case (write_addr_i)
				REG_SR:  sr_q  <= write_data_i & SR_WRITE_MASK;
				REG_EPC: epc_q <= write_data_i;
				default: ; // Cause stays read-only.
			endcase
		end else if (exit_isr_i) begin
			sr_q[SR_EXL_BIT] <= 1'b0;
		end
	end

	// IP comes live from irq_pending.
	always_comb begin
		cause_word                                 = '0;
		cause_word[CAUSE_BD_BIT]                   = bd_q;
		cause_word[CAUSE_IP_LSB +: NUM_HWIRQ]      = ip_i;
		cause_word[CAUSE_EXC_LSB +: EXC_CODE_W]    = exc_code_q;
	end

	always_comb begin
		case (read_addr_i)
			REG_SR:    read_data_o = sr_q;
			REG_CAUSE: read_data_o = cause_word;
			REG_EPC:   read_data_o = epc_q;
			REG_PRID:  read_data_o = CP0_PRID;
			default:   read_data_o = '0;
		endcase
	end

	assign epc_o = epc_q;

	// the handler must find EXL set right after the trap.
	a_exl_after_trap: assert property (
		@(posedge clk) disable iff (rst)
		trap_o |=> sr_q[SR_EXL_BIT]
	) else $error("EXL not set one cycle after trap_o");

	// no nested traps.
	a_no_trap_in_exl: assert property (
		@(posedge clk) disable iff (rst)
		sr_exl |-> !trap_o
	) else $error("trap_o raised while EXL is set");

endmodule

//--- rtl/exc_prioritizer.sv
`timescale 1ns/1ps

module exc_prioritizer (
	input  cp0_pkg::exc_flags_t flags_i,
	input  logic [31:0]         pc_i,
	input  logic                in_bds_i,
	trap_if.src                 trap
);
	import cp0_pkg::*;

	exc_code_e   code_sel;
	logic        any_flag;
	logic [31:0] epc_sel;

	// fixed order, the earliest pipeline fault wins.
	always_comb begin
		any_flag = |flags_i;
		code_sel = EXC_INT; // only a default, never reported with any_flag.
		if (flags_i.adel) begin
			code_sel = EXC_ADEL;
		end else if (flags_i.ri) begin
			code_sel = EXC_RI;
		end else if (flags_i.sys) begin
			code_sel = EXC_SYS;
		end else if (flags_i.ov) begin
			code_sel = EXC_OV;
		end else if (flags_i.ades) begin
			code_sel = EXC_ADES;
		end
	end

	// restart at the branch when the fault is in its delay slot.
	always_comb begin
		if (in_bds_i) begin
			epc_sel = pc_i - BDS_PC_OFFSET;
		end else begin
			epc_sel = pc_i;
		end
	end

	assign trap.exc_valid = any_flag;
	assign trap.exc_code  = code_sel;
	assign trap.exc_bds   = in_bds_i;
	assign trap.exc_epc   = epc_sel;

	// an exception must never look like an interrupt to cp0_regs.
	always_comb begin
		a_code_not_int: assert final (!(trap.exc_valid && trap.exc_code == EXC_INT))
			else $error("exception reported with code EXC_INT, flags %h", flags_i);
	end

endmodule

//--- rtl/irq_pending.sv
`timescale 1ns/1ps

module irq_pending (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [cp0_pkg::NUM_HWIRQ-1:0] hwirq_i,
	input  logic                          mtc0_cause_i,
	output logic [cp0_pkg::NUM_HWIRQ-1:0] ip_o
);
	import cp0_pkg::*;

	logic [NUM_HWIRQ-1:0] sync_q1;
	logic [NUM_HWIRQ-1:0] sync_q2;
	logic [NUM_HWIRQ-1:0] ip_q;

	// the lines come from outside the core clock domain.
	always_ff @(posedge clk) begin
		if (rst) begin
			sync_q1 <= '0;
			sync_q2 <= '0;
		end else begin
			sync_q1 <= hwirq_i;
			sync_q2 <= sync_q1;
		end
	end

	// Cause.IP follows the synchronized lines.
	// it holds still for one cycle while software writes Cause.
	always_ff @(posedge clk) begin
		if (rst) begin
			ip_q <= '0;
		end else if (!mtc0_cause_i) begin
			ip_q <= sync_q2;
		end
	end

	assign ip_o = ip_q;

	// the trap decision downstream must never see an unknown line.
	a_ip_known: assert property (
		@(posedge clk) disable iff (rst)
		!$isunknown(ip_o)
	) else $error("ip_o has unknown bits: %h", ip_o);

endmodule

//--- rtl/mips_exc_unit.sv
`timescale 1ns/1ps

module mips_exc_unit (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [cp0_pkg::NUM_HWIRQ-1:0] hwirq_i,
	input  logic                          adel_i,
	input  logic                          ades_i,
	input  logic                          sys_i,
	input  logic                          ri_i,
	input  logic                          ov_i,
	input  logic [31:0]                   pc_i,
	input  logic                          in_bds_i,
	input  logic                          write_en_i,
	input  logic [4:0]                    write_addr_i,
	input  logic [31:0]                   write_data_i,
	input  logic [4:0]                    read_addr_i,
	input  logic                          exit_isr_i,
	output logic [31:0]                   read_data_o,
	output logic [31:0]                   epc_o,
	output logic                          trap_o
);
	import cp0_pkg::*;

	exc_flags_t           flags;
	cp0_reg_e             write_addr;
	cp0_reg_e             read_addr;
	logic [NUM_HWIRQ-1:0] ip;
	logic                 mtc0_cause;

	trap_if trap ();

	assign flags.adel = adel_i;
	assign flags.ades = ades_i;
	assign flags.sys  = sys_i;
	assign flags.ri   = ri_i;
	assign flags.ov   = ov_i;

	// unused numbers pass through and read as zero.
	assign write_addr = cp0_reg_e'(write_addr_i);
	assign read_addr  = cp0_reg_e'(read_addr_i);

	irq_pending i_irq_pending (
		.clk          (clk),
		.rst          (rst),
		.hwirq_i      (hwirq_i),
		.mtc0_cause_i (mtc0_cause),
		.ip_o         (ip)
	);

	exc_prioritizer i_exc_prioritizer (
		.flags_i  (flags),
		.pc_i     (pc_i),
		.in_bds_i (in_bds_i),
		.trap     (trap.src)
	);

	cp0_regs i_cp0_regs (
		.clk          (clk),
		.rst          (rst),
		.trap         (trap.dst),
		.ip_i         (ip),
		.write_en_i   (write_en_i),
		.write_addr_i (write_addr),
		.write_data_i (write_data_i),
		.read_addr_i  (read_addr),
		.exit_isr_i   (exit_isr_i),
		.read_data_o  (read_data_o),
		.epc_o        (epc_o),
		.trap_o       (trap_o),
		.mtc0_cause_o (mtc0_cause)
	);

endmodule

//--- rtl/trap_if.sv
`timescale 1ns/1ps

interface trap_if;
	import cp0_pkg::*;

	logic        exc_valid; // some flag set this cycle.
	exc_code_e   exc_code;
	logic        exc_bds;
	logic [31:0] exc_epc;

	// prioritizer side.
	modport src (
		output exc_valid,
		output exc_code,
		output exc_bds,
		output exc_epc
	);

	// register file side.
	modport dst (
		input exc_valid,
		input exc_code,
		input exc_bds,
		input exc_epc
	);

endinterface
